//--- hist_bank.sv
`timescale 1ns/1ps

module hist_bank (
    input  logic      clk,
    input  logic      res,
    hist_bank_if.mem  port
);
    import hist_cfg_pkg::*;

    // one count per {pixel, bin}
    logic [CNT_W-1:0] mem [WORDS];
    // word under the increment address
    logic [CNT_W-1:0] cur_word;
    logic             sat;

    // array read feeds the adder directly
    // so back-to-back hits on one word accumulate
    assign cur_word = mem[port.inc_addr];
    assign sat      = cur_word == CNT_MAX;

    // read data visible in the same cycle
    assign port.rd_data = mem[port.rd_addr];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            // bank starts empty
            for (int i = 0; i < WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            // saturating increment
            if (port.inc_en && !sat) begin
                mem[port.inc_addr] <= cur_word + 1'b1;
            end
            // read-and-clear
            if (port.rd_en) begin
                mem[port.rd_addr] <= '0;
            end
        end
    end

    // controller writes one bank while the readout drains the other
    a_no_share: assert property (@(posedge clk) disable iff (!res)
        !(port.inc_en && port.rd_en));

    // an increment never lowers a word
    // so a full word holds at CNT_MAX
    a_no_wrap: assert property (@(posedge clk) disable iff (!res)
        port.inc_en |=> mem[$past(port.inc_addr)] >= $past(cur_word));

endmodule

//--- hist_bank_if.sv
`timescale 1ns/1ps

interface hist_bank_if;
    import hist_cfg_pkg::*;

    // increment side, level per cycle
    logic               inc_en;
    logic [WORD_AW-1:0] inc_addr;

    // read-and-clear side
    logic               rd_en;
    logic [WORD_AW-1:0] rd_addr;
    // combinational from the array
    logic [CNT_W-1:0]   rd_data;

    // controller side
    modport writer (
        output inc_en,
        output inc_addr
    );

    // readout side
    modport reader (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    // memory side
    modport mem (
        input  inc_en,
        input  inc_addr,
        input  rd_en,
        input  rd_addr,
        output rd_data
    );

endinterface

//--- hist_cfg_pkg.sv
package hist_cfg_pkg;

    // histogram geometry and counter sizes

    // bins per pixel histogram
    localparam int BIN_NUM = 8;
    // bits of a bin number
    localparam int BIN_W = $clog2(BIN_NUM);

    // pixels per acquisition
    localparam int PIX_NUM = 4;
    localparam int PIX_W = $clog2(PIX_NUM);

    // events per pixel in one acquisition
    localparam int EVT_PER_PIX = 2;
    localparam int EVT_W = $clog2(EVT_PER_PIX);

    // acquisitions per frame
    localparam int ACQ_NUM = 3;
    localparam int ACQ_W = $clog2(ACQ_NUM);

    // one bank holds every bin of every pixel
    localparam int WORDS = PIX_NUM * BIN_NUM;
    // word address is {pixel, bin}
    localparam int WORD_AW = $clog2(WORDS);

    // bin count width
    localparam int CNT_W = 4;
    // counts stop here
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

endpackage

//--- hist_ctrl.sv
`timescale 1ns/1ps

module hist_ctrl (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           wr_en,
    input  logic [hist_cfg_pkg::BIN_W-1:0] addr,
    input  logic                           busy,
    hist_bank_if.writer                    bank0,
    hist_bank_if.writer                    bank1,
    output logic                           his_num,
    output logic                           frame_done,
    output logic                           overrun
);
    import hist_cfg_pkg::*;
    import hist_types_pkg::*;

    ctrl_state_t        state;
    logic [EVT_W-1:0]   evt_cnt;
    logic [PIX_W-1:0]   pix_cnt;
    logic [ACQ_W-1:0]   acq_cnt;
    logic               accept;
    logic               evt_last;
    logic               pix_last;
    logic               acq_last;
    logic               frame_last;
    logic [WORD_AW-1:0] word_addr;

    // events only count while not waiting for the readout
    assign accept = wr_en && (state == COUNT);

    // terminal values of the three counters
    assign evt_last = evt_cnt == EVT_W'(EVT_PER_PIX - 1);
    assign pix_last = pix_cnt == PIX_W'(PIX_NUM - 1);
    assign acq_last = acq_cnt == ACQ_W'(ACQ_NUM - 1);

    // last event of the frame
    assign frame_last = accept && evt_last && pix_last && acq_last;

    // pixel-major word address
    assign word_addr = {pix_cnt, addr};

    // same address to both banks
    assign bank0.inc_addr = word_addr;
    assign bank1.inc_addr = word_addr;
    // only the bank picked by his_num counts
    assign bank0.inc_en = accept && !his_num;
    assign bank1.inc_en = accept && his_num;

    // event / pixel / acquisition counters
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evt_cnt <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
        end else if (accept) begin
            if (evt_last) begin
                evt_cnt <= '0;
                if (pix_last) begin
                    pix_cnt <= '0;
                    // wraps to zero on the frame's last event
                    if (acq_last) begin
                        acq_cnt <= '0;
                    end else begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end
                end else begin
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end else begin
                evt_cnt <= evt_cnt + 1'b1;
            end
        end
    end

    // frame end, bank swap and drain wait
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= COUNT;
            his_num    <= 1'b0;
            frame_done <= 1'b0;
            overrun    <= 1'b0;
        end else begin
            // single cycle pulse
            frame_done <= 1'b0;
            case (state)
                COUNT: begin
                    if (frame_last) begin
                        if (busy) begin
                            // other bank not drained yet
                            state   <= DRAIN_WAIT;
                            overrun <= 1'b1;
                        end else begin
                            his_num    <= ~his_num;
                            frame_done <= 1'b1;
                        end
                    end
                end
                DRAIN_WAIT: begin
                    // swap on the first idle cycle of the readout
                    if (!busy) begin
                        state      <= COUNT;
                        his_num    <= ~his_num;
                        frame_done <= 1'b1;
                    end
                end
                default: begin
                    state <= COUNT;
                end
            endcase
        end
    end

    // readout starts once per frame
    a_done_pulse: assert property (@(posedge clk) disable iff (!res)
        frame_done |=> !frame_done);

    // dropped events never advance the next frame
    a_wait_at_start: assert property (@(posedge clk) disable iff (!res)
        (state == DRAIN_WAIT) |-> (evt_cnt == '0 && pix_cnt == '0 && acq_cnt == '0));

endmodule

//--- hist_readout.sv
`timescale 1ns/1ps

module hist_readout (
    input  logic                           clk,
    input  logic                           res,
    input  logic                           frame_done,
    input  logic                           his_num,
    hist_bank_if.reader                    bank0,
    hist_bank_if.reader                    bank1,
    output logic                           busy,
    output logic                           out_valid,
    output logic [hist_cfg_pkg::PIX_W-1:0] out_pixel,
    output logic [hist_cfg_pkg::BIN_W-1:0] out_bin,
    output logic [hist_cfg_pkg::CNT_W-1:0] out_count
);
    import hist_cfg_pkg::*;

    logic [WORD_AW-1:0] wcnt;
    logic               sel_q;
    logic               rd_sel;
    logic               rd_act;
    logic               wlast;
    logic [CNT_W-1:0]   rd_data;

    // word 0 is read in the frame_done cycle itself
    assign rd_act = frame_done || busy;
    assign wlast  = wcnt == WORD_AW'(WORDS - 1);

    // finished bank is the one opposite the new his_num
    assign rd_sel = frame_done ? ~his_num : sel_q;

    // walk address shared by both banks
    assign bank0.rd_addr = wcnt;
    assign bank1.rd_addr = wcnt;
    // clear only in the bank being drained
    assign bank0.rd_en = rd_act && !rd_sel;
    assign bank1.rd_en = rd_act && rd_sel;

    assign rd_data = rd_sel ? bank1.rd_data : bank0.rd_data;

    // pass control
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy      <= 1'b0;
            sel_q     <= 1'b0;
            wcnt      <= '0;
            out_valid <= 1'b0;
        end else begin
            // one beat per read
            out_valid <= rd_act;
            if (frame_done) begin
                // latch bank for the whole pass
                sel_q <= ~his_num;
                busy  <= 1'b1;
                wcnt  <= wcnt + 1'b1;
            end else if (busy) begin
                if (wlast) begin
                    // last word issued
                    busy <= 1'b0;
                    wcnt <= '0;
                end else begin
                    wcnt <= wcnt + 1'b1;
                end
            end
        end
    end

    // beat payload
    // pixel from the upper address bits and bin from the lower
    always_ff @(posedge clk) begin
        out_count <= rd_data;
        out_pixel <= wcnt[WORD_AW-1:BIN_W];
        out_bin   <= wcnt[BIN_W-1:0];
    end

    // beats come while busy, or as the pass's last word
    a_beat_in_pass: assert property (@(posedge clk) disable iff (!res)
        (out_valid && !busy) |-> $past(wlast));

    // controller never restarts a pass in progress
    a_no_restart: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> !busy);

endmodule

//--- hist_top.sv
`timescale 1ns/1ps

module hist_top (
    input  logic                           clk,
    input  logic                           res,
    // event strobe with its bin number
    input  logic                           wr_en,
    input  logic [hist_cfg_pkg::BIN_W-1:0] addr,
    // bank currently counting
    output logic                           his_num,
    output logic                           frame_done,
    // sticky, a frame ended during a readout pass
    output logic                           overrun,
    output logic                           busy,
    // histogram stream
    output logic                           out_valid,
    output logic [hist_cfg_pkg::PIX_W-1:0] out_pixel,
    output logic [hist_cfg_pkg::BIN_W-1:0] out_bin,
    output logic [hist_cfg_pkg::CNT_W-1:0] out_count
);

    // ping-pong bank ports
    hist_bank_if bank0_if ();
    hist_bank_if bank1_if ();

    // counting and bank swap
    hist_ctrl u_ctrl (
        .clk        (clk),
        .res        (res),
        .wr_en      (wr_en),
        .addr       (addr),
        .busy       (busy),
        .bank0      (bank0_if),
        .bank1      (bank1_if),
        .his_num    (his_num),
        .frame_done (frame_done),
        .overrun    (overrun)
    );

    // bank 0 memory
    hist_bank u_bank0 (
        .clk  (clk),
        .res  (res),
        .port (bank0_if)
    );

    // bank 1 memory
    hist_bank u_bank1 (
        .clk  (clk),
        .res  (res),
        .port (bank1_if)
    );

    // drains the finished bank
    hist_readout u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .his_num    (his_num),
        .bank0      (bank0_if),
        .bank1      (bank1_if),
        .busy       (busy),
        .out_valid  (out_valid),
        .out_pixel  (out_pixel),
        .out_bin    (out_bin),
        .out_count  (out_count)
    );

endmodule

//--- hist_types_pkg.sv
package hist_types_pkg;

    // controller states
    // COUNT       events go into the active bank
    // DRAIN_WAIT  frame is complete but the other bank is still streaming
    //             events are dropped until the readout goes idle
    typedef enum logic [1:0] {
        COUNT      = 2'b00,
        DRAIN_WAIT = 2'b01
    } ctrl_state_t;

endpackage

//--- list.f
hist_cfg_pkg.sv
hist_types_pkg.sv
hist_bank_if.sv
hist_ctrl.sv
hist_bank.sv
hist_readout.sv
hist_top.sv
tb_clk_gen.sv
tb_hist_top.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator and run from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_hist_top -o sim_hist -f list.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_hist)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1

//--- tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);
    // free running, 10 ns period
    initial begin
        clk = 1'b0;
    end

    always begin
        #5 clk = ~clk;
    end

endmodule

//--- tb_hist_top.sv
`timescale 1ns/1ps

module tb_hist_top;
    import hist_cfg_pkg::*;
    import hist_types_pkg::*;

    // cycles any single wait may take
    localparam int WAIT_MAX = 400;
    // bin patterns of a frame
    localparam int MODE_RAND = 0;
    localparam int MODE_ZERO = 1;
    localparam int MODE_PIX  = 2;

    logic             clk;
    logic             res;
    logic             wr_en;
    logic [BIN_W-1:0] addr;
    logic             his_num;
    logic             frame_done;
    logic             overrun;
    logic             busy;
    logic             out_valid;
    logic [PIX_W-1:0] out_pixel;
    logic [BIN_W-1:0] out_bin;
    logic [CNT_W-1:0] out_count;

    int    seed;
    string cur_test;
    int    err_at_start;
    int    chk_err;
    int    mon_err;
    int    prop_err;
    int    tests_run;
    int    tests_failed;
    bit    timed_out;

    // reference histograms, one per bank
    int               model_cnt [2][WORDS];
    // expected words of the stream in flight
    int               exp_snap [WORDS];
    logic [CNT_W-1:0] exp_beat;
    bit               m_his;
    int               m_evt;
    int               m_pix;
    int               m_acq;
    // banks the model has closed, in frame order
    bit               fin_bank [16];
    int               fin_wr;
    int               fin_rd;
    int               fd_cnt;
    // beats seen so far in the current run of out_valid
    int               run_len;

    tb_clk_gen u_clk (.clk(clk));

    hist_top u_dut (.*);

    always_comb begin
        exp_beat = CNT_W'(exp_snap[{out_pixel, out_bin}]);
    end

    always @(posedge clk or negedge res) begin
        if (!res) begin
            run_len <= 0;
        end else if (out_valid) begin
            run_len <= run_len + 1;
        end else begin
            run_len <= 0;
        end
    end

    // frame_done bookkeeping, mid-cycle where outputs are settled
    always @(negedge clk) begin
        if (res && frame_done) begin
            fd_cnt <= fd_cnt + 1;
            assert (fin_wr != fin_rd) else begin
                $display("%s: frame_done pulsed with no finished frame", cur_test);
                mon_err++;
            end
            if (fin_wr != fin_rd) begin
                // finished bank becomes the expected stream
                for (int i = 0; i < WORDS; i++) begin
                    exp_snap[i] = model_cnt[fin_bank[fin_rd % 16]][i];
                end
                fin_rd++;
            end
        end
    end

    // stream opens one cycle after frame_done
    a_start: assert property (@(posedge clk) disable iff (!res)
        $rose(out_valid) |-> $past(frame_done)) else begin
        $display("%s: stream began without frame_done the cycle before", cur_test);
        prop_err++;
    end

    a_len: assert property (@(posedge clk) disable iff (!res)
        $fell(out_valid) |-> run_len == WORDS) else begin
        $display("ERR %s stream length expected %0d actual %0d",
            cur_test, WORDS, $sampled(run_len));
        prop_err++;
    end

    // pixel-major, bin ascending
    a_order: assert property (@(posedge clk) disable iff (!res)
        out_valid |-> {out_pixel, out_bin} == WORD_AW'(run_len)) else begin
        $display("ERR %s beat address expected %0d actual %0d",
            cur_test, $sampled(run_len), $sampled({out_pixel, out_bin}));
        prop_err++;
    end

    a_count: assert property (@(posedge clk) disable iff (!res)
        out_valid |-> out_count == exp_beat) else begin
        $display("ERR %s count pixel %0d bin %0d expected %0d actual %0d", cur_test,
            $sampled(out_pixel), $sampled(out_bin), $sampled(exp_beat), $sampled(out_count));
        prop_err++;
    end

    a_toggle: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> his_num != $past(his_num)) else begin
        $display("%s: his_num did not toggle with frame_done", cur_test);
        prop_err++;
    end

    // swap only once the previous pass is drained
    a_drained: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> !$past(busy)) else begin
        $display("%s: frame_done came while the readout was busy", cur_test);
        prop_err++;
    end

    a_sticky: assert property (@(posedge clk) disable iff (!res)
        overrun |=> overrun) else begin
        $display("%s: overrun flag fell before reset", cur_test);
        prop_err++;
    end

    a_wait_flag: assert property (@(posedge clk) disable iff (!res)
        (u_dut.u_ctrl.state == DRAIN_WAIT) |-> overrun) else begin
        $display("%s: controller waits for the drain but overrun is low", cur_test);
        prop_err++;
    end

    function automatic int total_err();
        return chk_err + mon_err + prop_err;
    endfunction

    task automatic check_val(input string what, input int exp, input int act);
        assert (exp == act) else begin
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
            chk_err++;
        end
    endtask

    // counting rules of one accepted event
    task automatic model_event(input logic [BIN_W-1:0] bin);
        int idx;
        // bank was read and cleared before this frame
        if (m_evt == 0 && m_pix == 0 && m_acq == 0) begin
            for (int i = 0; i < WORDS; i++) begin
                model_cnt[m_his][i] = 0;
            end
        end
        idx = m_pix * BIN_NUM + int'(bin);
        if (model_cnt[m_his][idx] < int'(CNT_MAX)) begin
            model_cnt[m_his][idx]++;
        end
        m_evt++;
        if (m_evt == EVT_PER_PIX) begin
            m_evt = 0;
            m_pix++;
        end
        if (m_pix == PIX_NUM) begin
            m_pix = 0;
            m_acq++;
        end
        if (m_acq == ACQ_NUM) begin
            // frame closed, counting moves to the other bank
            m_acq = 0;
            fin_bank[fin_wr % 16] = m_his;
            fin_wr++;
            m_his = !m_his;
        end
    endtask

    task automatic send_event(input logic [BIN_W-1:0] bin, input bit counted);
        @(posedge clk);
        wr_en <= 1'b1;
        addr  <= bin;
        if (counted) begin
            model_event(bin);
        end
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            wr_en <= 1'b0;
        end
    endtask

    task automatic run_frame(input int mode, input bit gaps);
        logic [BIN_W-1:0] pix_bin [PIX_NUM];
        logic [BIN_W-1:0] bin;
        for (int p = 0; p < PIX_NUM; p++) begin
            pix_bin[p] = BIN_W'($unsigned($random(seed)));
        end
        for (int a = 0; a < ACQ_NUM; a++) begin
            for (int p = 0; p < PIX_NUM; p++) begin
                for (int e = 0; e < EVT_PER_PIX; e++) begin
                    case (mode)
                        MODE_RAND: bin = BIN_W'($unsigned($random(seed)));
                        MODE_ZERO: bin = '0;
                        default:   bin = pix_bin[p];
                    endcase
                    send_event(bin, 1'b1);
                    if (gaps) begin
                        idle($unsigned($random(seed)) % 3);
                    end
                end
            end
        end
    endtask

    task automatic wait_frames(input int target);
        int n;
        if (timed_out) begin
            return;
        end
        n = 0;
        while (fd_cnt < target && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (fd_cnt < target) begin
            $display("%s: timed out waiting for frame_done", cur_test);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_stream_end();
        int n;
        bit seen;
        bit done;
        if (timed_out) begin
            return;
        end
        n = 0;
        seen = 1'b0;
        done = 1'b0;
        while (!done && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
            if (out_valid) begin
                seen = 1'b1;
            end else if (seen) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            $display("%s: timed out waiting for the end of the stream", cur_test);
            timed_out = 1'b1;
        end
    endtask

    // one frame, then its full stream
    task automatic frame_and_drain(input int mode, input bit gaps);
        int start;
        start = fd_cnt;
        run_frame(mode, gaps);
        idle(1);
        wait_frames(start + 1);
        wait_stream_end();
    endtask

    task automatic begin_test(input string name);
        cur_test = name;
        err_at_start = total_err();
    endtask

    task automatic end_test();
        tests_run++;
        if (timed_out) begin
            tests_failed++;
            $display("test %s stopped by a timeout", cur_test);
        end else if (total_err() != err_at_start) begin
            tests_failed++;
            $display("test %s failed with %0d errors", cur_test, total_err() - err_at_start);
        end else begin
            $display("test %s passed", cur_test);
        end
    endtask

    initial begin
        int start;
        seed = 44;
        res = 1'b0;
        wr_en = 1'b0;
        addr = '0;
        repeat (10) @(posedge clk);
        res <= 1'b1;

        begin_test("reset");
        @(negedge clk);
        check_val("his_num", 0, int'(his_num));
        check_val("frame_done", 0, int'(frame_done));
        check_val("overrun", 0, int'(overrun));
        check_val("busy", 0, int'(busy));
        check_val("out_valid", 0, int'(out_valid));
        end_test();

        // random bins with random gaps, readout idle
        begin_test("frame_stream");
        start = fd_cnt;
        frame_and_drain(MODE_RAND, 1'b1);
        check_val("frame_done pulses", 1, fd_cnt - start);
        check_val("his_num", int'(m_his), int'(his_num));
        end_test();

        // second frame refills bank 0 after its read-and-clear
        begin_test("read_clear");
        frame_and_drain(MODE_ZERO, 1'b1);
        frame_and_drain(MODE_ZERO, 1'b0);
        check_val("his_num", int'(m_his), int'(his_num));
        end_test();

        // six hits per pixel on one bin
        begin_test("exact_count");
        frame_and_drain(MODE_PIX, 1'b1);
        end_test();

        // back-to-back frames, second one ends mid-stream
        begin_test("overrun");
        start = fd_cnt;
        check_val("overrun before", 0, int'(overrun));
        run_frame(MODE_RAND, 1'b0);
        run_frame(MODE_RAND, 1'b0);
        // dropped while the controller waits for the drain
        for (int i = 0; i < 6; i++) begin
            send_event(BIN_W'($unsigned($random(seed))), 1'b0);
        end
        idle(1);
        wait_frames(start + 2);
        wait_stream_end();
        check_val("overrun", 1, int'(overrun));
        check_val("frame_done pulses", 2, fd_cnt - start);
        check_val("his_num", int'(m_his), int'(his_num));
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
            tests_run, tests_failed, total_err());
        if (!timed_out && tests_failed == 0 && total_err() == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
